//--- common/sha_types_pkg.sv
// Data shapes shared by the SHA-256 blocks.
// Words are 32 bits and big-endian. Block word 0 is the first message word.
package sha_types_pkg;

	// One SHA-256 word
	typedef logic [31:0] word_t;

	// Padded 512-bit message block, index 0 holds the first word
	typedef word_t [15:0] block_t;

	// Round index, 0 to 63
	typedef logic [5:0] round_idx_t;

	// Working variables of the compression function
	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} work_state_t;

	// Chaining value, h0 is the most significant output word
	typedef struct packed {
		word_t h0;
		word_t h1;
		word_t h2;
		word_t h3;
		word_t h4;
		word_t h5;
		word_t h6;
		word_t h7;
	} digest_t;

endpackage

//--- common/sha_consts_pkg.sv
// SHA-256 algorithm constants and mixing functions, per FIPS 180-4.
// Depends on sha_types_pkg for the word and digest shapes.
package sha_consts_pkg;
	import sha_types_pkg::*;

	localparam int NUM_ROUNDS = 64;

	// Round constants K0..K63
	localparam word_t ROUND_K [NUM_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash value for a new message
	localparam digest_t INIT_HASH = '{
		h0: 32'h6a09e667, h1: 32'hbb67ae85, h2: 32'h3c6ef372, h3: 32'ha54ff53a,
		h4: 32'h510e527f, h5: 32'h9b05688c, h6: 32'h1f83d9ab, h7: 32'h5be0cd19
	};

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

endpackage

//--- message_schedule/message_schedule.sv
// Message schedule with a sixteen-word sliding window.
// Rounds 0-15 read the loaded block directly, later rounds expand and shift.
// sched_word is combinational from round_idx and valid in the same cycle.
`timescale 1ns/1ps

module message_schedule (
	input  logic                      tb_clk,
	input  logic                      rst_n,
	input  logic                      accept,
	input  sha_types_pkg::block_t     block,
	input  sha_types_pkg::round_idx_t round_idx,
	output sha_types_pkg::word_t      sched_word
);
	import sha_types_pkg::*;
	import sha_consts_pkg::*;

	block_t win;
	word_t  next_word;
	logic   expand;

	// Rounds 16 and up derive their word from the window
	assign expand = (round_idx[5:4] != 2'b00);

	// Window holds W[t-16]..W[t-1] in entries 0..15 while expanding
	assign next_word = small_sigma1(win[14]) + win[9] + small_sigma0(win[1]) + win[0];

	assign sched_word = expand ? next_word : win[round_idx[3:0]];

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			win <= '0;
		end
		else if (accept)
		begin
			win <= block;
		end
		else if (expand)
		begin
			// Drop the oldest word, append the new one at the top
			win <= {next_word, win[15:1]};
		end
	end

endmodule

//--- round_engine/round_engine.sv
// Round engine, one SHA-256 round per clock.
// A start is taken only while idle, otherwise it is dropped silently.
// Busy stays high for one extra cycle after round 63 for the final add.
`timescale 1ns/1ps

module round_engine (
	input  logic                       tb_clk,
	input  logic                       rst_n,
	input  logic                       start,
	input  sha_types_pkg::digest_t     chain_in,
	input  sha_types_pkg::word_t       sched_word,
	output logic                       accept,
	output logic                       busy,
	output sha_types_pkg::round_idx_t  round_idx,
	output logic                       last_round,
	output sha_types_pkg::work_state_t final_state
);
	import sha_types_pkg::*;
	import sha_consts_pkg::*;

	work_state_t st;
	work_state_t st_next;
	logic        finishing;
	word_t       ch;
	word_t       maj;
	word_t       t1;
	word_t       t2;

	assign accept = start && !busy;
	assign last_round = busy && !finishing && (round_idx == round_idx_t'(NUM_ROUNDS - 1));
	assign final_state = st;

	// Control: busy, round counter, wrap-up cycle
	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			finishing <= 1'b0;
			round_idx <= '0;
		end
		else if (accept)
		begin
			busy      <= 1'b1;
			round_idx <= '0;
		end
		else if (finishing)
		begin
			busy      <= 1'b0;
			finishing <= 1'b0;
		end
		else if (busy)
		begin
			// Counter wraps back to 0 after round 63
			round_idx <= round_idx + 1'b1;
			if (last_round)
			begin
				finishing <= 1'b1;
			end
		end
	end

	// One compression round
	always_comb
	begin
		ch  = (st.e & st.f) ^ (~st.e & st.g);
		maj = (st.a & st.b) ^ (st.a & st.c) ^ (st.b & st.c);
		t1  = st.h + big_sigma1(st.e) + ch + ROUND_K[round_idx] + sched_word;
		t2  = big_sigma0(st.a) + maj;

		st_next.a = t1 + t2;
		st_next.b = st.a;
		st_next.c = st.b;
		st_next.d = st.c;
		st_next.e = st.d + t1;
		st_next.f = st.e;
		st_next.g = st.f;
		st_next.h = st.g;
	end

	always_ff @(posedge tb_clk)
	begin
		if (accept)
		begin
			st <= '{a: chain_in.h0, b: chain_in.h1, c: chain_in.h2, d: chain_in.h3,
				e: chain_in.h4, f: chain_in.h5, g: chain_in.h6, h: chain_in.h7};
		end
		else if (busy && !finishing)
		begin
			st <= st_next;
		end
	end

endmodule

//--- logic/digest_accumulator.sv
// Chaining digest register and the final per-word addition.
// With first high at accept the chain restarts from the initial hash value.
// Digest holds from one done pulse to the next.
`timescale 1ns/1ps

module digest_accumulator (
	input  logic                       tb_clk,
	input  logic                       rst_n,
	input  logic                       accept,
	input  logic                       first,
	input  logic                       last_round,
	input  sha_types_pkg::work_state_t final_state,
	output sha_types_pkg::digest_t     chain_in,
	output logic                       done,
	output sha_types_pkg::digest_t     digest
);
	import sha_types_pkg::*;
	import sha_consts_pkg::*;

	digest_t digest_q;
	digest_t base;
	digest_t sum;
	logic    first_q;
	logic    add_pending;

	// Starting point for the working variables
	assign chain_in = first ? INIT_HASH : digest_q;

	// Same base as used at accept
	assign base = first_q ? INIT_HASH : digest_q;

	always_comb
	begin
		sum.h0 = base.h0 + final_state.a;
		sum.h1 = base.h1 + final_state.b;
		sum.h2 = base.h2 + final_state.c;
		sum.h3 = base.h3 + final_state.d;
		sum.h4 = base.h4 + final_state.e;
		sum.h5 = base.h5 + final_state.f;
		sum.h6 = base.h6 + final_state.g;
		sum.h7 = base.h7 + final_state.h;
	end

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			first_q     <= 1'b0;
			add_pending <= 1'b0;
			done        <= 1'b0;
			digest_q    <= INIT_HASH;
		end
		else
		begin
			// final_state carries round 63 one cycle after last_round
			add_pending <= last_round;
			done        <= add_pending;
			if (accept)
			begin
				first_q <= first;
			end
			if (add_pending)
			begin
				digest_q <= sum;
			end
		end
	end

	assign digest = digest_q;

endmodule

//--- logic/sha256_core.sv
// Iterative SHA-256 compression core, one 512-bit padded block per start.
// No padding is done here. Done follows an accepted start by 65 cycles.
// Starts while busy are ignored.
`timescale 1ns/1ps

module sha256_core (
	input  logic                   tb_clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic                   first,
	input  sha_types_pkg::block_t  block,
	output logic                   busy,
	output logic                   done,
	output sha_types_pkg::digest_t digest
);
	import sha_types_pkg::*;

	logic        accept;
	logic        last_round;
	round_idx_t  round_idx;
	word_t       sched_word;
	digest_t     chain_in;
	work_state_t final_state;

	message_schedule u_sched (
		.tb_clk     (tb_clk),
		.rst_n      (rst_n),
		.accept     (accept),
		.block      (block),
		.round_idx  (round_idx),
		.sched_word (sched_word)
	);

	round_engine u_engine (
		.tb_clk      (tb_clk),
		.rst_n       (rst_n),
		.start       (start),
		.chain_in    (chain_in),
		.sched_word  (sched_word),
		.accept      (accept),
		.busy        (busy),
		.round_idx   (round_idx),
		.last_round  (last_round),
		.final_state (final_state)
	);

	digest_accumulator u_accum (
		.tb_clk      (tb_clk),
		.rst_n       (rst_n),
		.accept      (accept),
		.first       (first),
		.last_round  (last_round),
		.final_state (final_state),
		.chain_in    (chain_in),
		.done        (done),
		.digest      (digest)
	);

endmodule

//--- testbench/sha256_core_props.sv
// Timing properties of the SHA-256 core, bound into sha256_core.
// Done is sampled 66 edges after the accept sample. That is the load edge,
// 64 round edges and the add edge. Failures are counted in assert_fails.
`timescale 1ns/1ps

module sha256_core_props (
	input logic                   tb_clk,
	input logic                   rst_n,
	input logic                   accept,
	input logic                   busy,
	input logic                   done,
	input sha_types_pkg::digest_t digest
);
	import sha_types_pkg::*;
	import sha_consts_pkg::*;

	localparam int DONE_DELAY = NUM_ROUNDS + 2;

	int assert_fails = 0;

	// Samples of the current block still to come with busy high
	int busy_left;

	always @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			busy_left <= 0;
		end
		else if (accept)
		begin
			busy_left <= DONE_DELAY - 1;
		end
		else if (busy_left != 0)
		begin
			busy_left <= busy_left - 1;
		end
	end

	reset_state: assert property (@(posedge tb_clk)
		$rose(rst_n) |-> (!busy && !done && digest == INIT_HASH))
	else
	begin
		$error("core not idle with the initial hash after reset");
		assert_fails++;
	end

	// Every accept gets its done
	accept_gives_done: assert property (@(posedge tb_clk) disable iff (!rst_n)
		$past(accept, DONE_DELAY) |-> done)
	else
	begin
		$error("done missing 65 cycles after an accepted start");
		assert_fails++;
	end

	done_needs_accept: assert property (@(posedge tb_clk) disable iff (!rst_n)
		done |-> $past(accept, DONE_DELAY))
	else
	begin
		$error("done without an accepted start 65 cycles earlier");
		assert_fails++;
	end

	// Busy from the load edge through the add edge
	busy_through_block: assert property (@(posedge tb_clk) disable iff (!rst_n)
		(busy_left != 0) |-> busy)
	else
	begin
		$error("busy was low while a block was still in flight");
		assert_fails++;
	end

	// Busy only drops together with done
	busy_falls_at_done: assert property (@(posedge tb_clk) disable iff (!rst_n)
		$fell(busy) |-> done)
	else
	begin
		$error("busy fell before the block was done");
		assert_fails++;
	end

	done_after_busy: assert property (@(posedge tb_clk) disable iff (!rst_n)
		done |-> $past(busy))
	else
	begin
		$error("done arrived without busy in the cycle before");
		assert_fails++;
	end

	digest_stable: assert property (@(posedge tb_clk) disable iff (!rst_n)
		!$stable(digest) |-> done)
	else
	begin
		$error("digest changed outside a done pulse");
		assert_fails++;
	end

endmodule

bind sha256_core sha256_core_props u_props (
	.tb_clk (tb_clk),
	.rst_n  (rst_n),
	.accept (accept),
	.busy   (busy),
	.done   (done),
	.digest (digest)
);

//--- testbench/tb_sha256_core.sv
// Testbench for the SHA-256 core with the FIPS 180-4 example vectors.
// Blocks are padded here. Cycle timing is checked by the bound properties.
// Inputs change 5 ns after the rising edge and outputs are sampled 1 ns after it.
`timescale 1ns/1ps

module tb_sha256_core;
	import sha_types_pkg::*;

	// Six blocks, random gaps and the idle tail take about 520 cycles
	localparam int TIMEOUT_CYCLES = 1000;
	localparam int DONE_LATENCY   = 65;
	localparam int NUM_BLOCKS     = 6;

	// Padded blocks, first message word in the top bits
	localparam logic [511:0] ABC_MSG = {32'h61626380, {14{32'h00000000}}, 32'h00000018};
	localparam logic [511:0] LONG_MSG1 = {
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071, 32'h80000000, 32'h00000000
	};
	localparam logic [511:0] LONG_MSG2 = {{15{32'h00000000}}, 32'h000001c0};

	// Published digests and the standard initial hash value
	localparam digest_t INIT_DIGEST = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};
	localparam digest_t ABC_DIGEST = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};
	localparam digest_t LONG_DIGEST = {
		32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
		32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
	};

	logic    tb_clk;
	logic    rst_n;
	logic    start;
	logic    first;
	block_t  block;
	logic    busy;
	logic    done;
	digest_t digest;

	int cycle      = 0;
	int errors     = 0;
	int done_count = 0;

	sha256_core uut (
		.tb_clk (tb_clk),
		.rst_n  (rst_n),
		.start  (start),
		.first  (first),
		.block  (block),
		.busy   (busy),
		.done   (done),
		.digest (digest)
	);

	always #50 tb_clk = ~tb_clk;

	// Cycle count and run limit
	always @(posedge tb_clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	always @(negedge tb_clk)
	begin
		if (done)
		begin
			done_count <= done_count + 1;
		end
	end

	// Message order to block_t, word 0 is the first word
	function automatic block_t to_block(input logic [511:0] msg);
		block_t blk;
		for (int i = 0; i < 16; i++)
		begin
			blk[i] = msg[511 - 32 * i -: 32];
		end
		return blk;
	endfunction

	task automatic check_value(input string name, input logic [255:0] expected,
		input logic [255:0] actual);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH %s: expected %0h, got %0h", name, expected, actual);
			errors++;
		end
	endtask

	// One start pulse, at_cycle is the count after the accepting edge
	task automatic start_block(input logic [511:0] msg, input logic is_first,
		output int at_cycle);
		@(posedge tb_clk);
		#5;
		start = 1'b1;
		first = is_first;
		block = to_block(msg);
		@(posedge tb_clk);
		#5;
		at_cycle = cycle;
		start = 1'b0;
		first = 1'b0;
	endtask

	task automatic wait_done(input int since, output int latency);
		do
		begin
			@(posedge tb_clk);
			#1;
		end
		while (!done);
		latency = cycle - since;
	endtask

	task automatic run_block(input logic [511:0] msg, input logic is_first);
		int t0;
		int lat;
		start_block(msg, is_first, t0);
		wait_done(t0, lat);
		check_value("done latency", DONE_LATENCY, lat);
	endtask

	task automatic idle_gap;
		int gap;
		gap = $urandom % 8;
		repeat (gap) @(posedge tb_clk);
	endtask

	initial
	begin
		int t0;
		int lat;
		void'($urandom(32'h5ecf_f825));
		tb_clk = 1'b0;
		rst_n  = 1'b0;
		start  = 1'b0;
		first  = 1'b0;
		block  = '0;
		repeat (4) @(posedge tb_clk);
		#5;
		rst_n = 1'b1;

		@(posedge tb_clk);
		#1;
		check_value("busy after reset", '0, busy);
		check_value("done after reset", '0, done);
		check_value("digest after reset", INIT_DIGEST, digest);

		// One-block message
		idle_gap();
		run_block(ABC_MSG, 1'b1);
		check_value("digest abc", ABC_DIGEST, digest);

		// Two-block chain
		idle_gap();
		run_block(LONG_MSG1, 1'b1);
		idle_gap();
		run_block(LONG_MSG2, 1'b0);
		check_value("digest two-block", LONG_DIGEST, digest);

		// First high again starts a new message
		idle_gap();
		run_block(ABC_MSG, 1'b1);
		check_value("digest abc after chain", ABC_DIGEST, digest);

		// Second block gets a stray start in the middle of its rounds
		idle_gap();
		run_block(LONG_MSG1, 1'b1);
		idle_gap();
		start_block(LONG_MSG2, 1'b0, t0);
		repeat (20) @(posedge tb_clk);
		#5;
		start = 1'b1;
		first = 1'b1;
		block = to_block(ABC_MSG);
		@(posedge tb_clk);
		#5;
		start = 1'b0;
		first = 1'b0;
		wait_done(t0, lat);
		check_value("done latency", DONE_LATENCY, lat);
		check_value("digest two-block with stray start", LONG_DIGEST, digest);

		// No late done from the stray start
		repeat (DONE_LATENCY + 5) @(posedge tb_clk);
		#1;
		check_value("done pulse count", NUM_BLOCKS, done_count);

		$display("Errors: %0d check failures, %0d assertion failures",
			errors, uut.u_props.assert_fails);
		if (errors == 0 && uut.u_props.assert_fails == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sha256_core.f
common/sha_types_pkg.sv
common/sha_consts_pkg.sv
message_schedule/message_schedule.sv
round_engine/round_engine.sv
logic/digest_accumulator.sv
logic/sha256_core.sv
testbench/sha256_core_props.sv
testbench/tb_sha256_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SHA-256 core testbench with Verilator, result in sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sha256_core \
	-f sha256_core.f -o sim_tb \
	&& ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
